//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_riscv_mem_top
FILELIST = files.f

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- bram_port_adapter.sv
`timescale 1ns/10ps

module bram_port_adapter (
   input  logic                  clk,
   input  logic                  reset,
   mem_req_if.responder          bus,
   output logic                  enb_o,
   output riscv_mem_pkg::be_t    web_o,
   output riscv_mem_pkg::word_t  addrb_o,
   output riscv_mem_pkg::word_t  dinb_o,
   input  logic                  rstb_busy_i,
   input  riscv_mem_pkg::word_t  doutb_i
);

   logic accept;
   logic rd_accept;
   logic rvalid_q;

   // busy BRAM holds the requester off
   assign bus.gnt   = ~rstb_busy_i;
   assign accept    = bus.req & bus.gnt;
   assign rd_accept = accept & ~bus.we;

   assign enb_o   = accept;
   assign web_o   = (accept && bus.we) ? bus.be : '0;
   // BRAM is addressed in words
   assign addrb_o = {2'b00, bus.addr[31:2]};
   assign dinb_o  = bus.wdata;

   // BRAM read latency is one cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_accept;
      end
   end

   assign bus.rvalid = rvalid_q;
   assign bus.rdata  = doutb_i;

   a_rvalid_after_read: assert property (
      @(posedge clk) disable iff (reset)
         bus.rvalid |-> $past(bus.req && bus.gnt && !bus.we)
   );

endmodule

//--- data_port_router.sv
`timescale 1ns/10ps

module data_port_router #(
   parameter riscv_mem_pkg::word_t PERIPH_BASE = riscv_mem_pkg::PERIPH_BASE_DEF,
   parameter riscv_mem_pkg::word_t TOHOST_ADDR = riscv_mem_pkg::TOHOST_ADDR_DEF
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  run_en_i,
   input  logic                  req_i,
   input  riscv_mem_pkg::word_t  addr_i,
   input  logic                  we_i,
   input  riscv_mem_pkg::be_t    be_i,
   input  riscv_mem_pkg::word_t  wdata_i,
   input  riscv_mem_pkg::word_t  memory_offset_i,
   input  riscv_mem_pkg::word_t  success_code_i,
   output logic                  gnt_o,
   output logic                  rvalid_o,
   output riscv_mem_pkg::word_t  rdata_o,
   output logic                  finish_o,
   mem_req_if.requester          data_bus,
   mem_req_if.requester          periph_bus
);

   logic is_periph;
   logic req_gated;
   logic sel_gnt;
   logic accepted;
   logic rd_periph_q;

   assign is_periph = (addr_i >= PERIPH_BASE);
   // nothing leaves the core side unless the design runs
   assign req_gated = req_i & run_en_i;

   assign data_bus.req   = req_gated & ~is_periph;
   assign data_bus.addr  = addr_i - memory_offset_i;
   assign data_bus.we    = we_i;
   assign data_bus.be    = be_i;
   assign data_bus.wdata = wdata_i;

   assign periph_bus.req   = req_gated & is_periph;
   assign periph_bus.addr  = addr_i - PERIPH_BASE;
   assign periph_bus.we    = we_i;
   assign periph_bus.be    = be_i;
   assign periph_bus.wdata = wdata_i;

   assign sel_gnt  = is_periph ? periph_bus.gnt : data_bus.gnt;
   assign gnt_o    = run_en_i & sel_gnt;
   assign accepted = req_gated & sel_gnt;

   // target of the last accepted read steers the response
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_periph_q <= 1'b0;
      end else if (accepted && !we_i) begin
         rd_periph_q <= is_periph;
      end
   end

   assign rvalid_o = rd_periph_q ? periph_bus.rvalid : data_bus.rvalid;
   assign rdata_o  = rd_periph_q ? periph_bus.rdata : data_bus.rdata;

   // success store to tohost ends the program
   assign finish_o = accepted & we_i & (addr_i == TOHOST_ADDR) &
                     (wdata_i == success_code_i);

   // a response only follows a read accepted in the cycle before
   a_rvalid_follows_read: assert property (
      @(posedge clk) disable iff (reset) rvalid_o |-> $past(accepted && !we_i)
   );

endmodule

//--- files.f
riscv_mem_pkg.sv
mem_req_if.sv
run_control.sv
data_port_router.sv
bram_port_adapter.sv
riscv_mem_top.sv
tb_checker.sv
tb_riscv_mem_top.sv

//--- mem_req_if.sv
`timescale 1ns/10ps

interface mem_req_if;
   import riscv_mem_pkg::*;

   // requester side
   logic  req;
   word_t addr;
   logic  we;
   be_t   be;
   word_t wdata;

   // responder side
   logic  gnt;
   logic  rvalid;
   word_t rdata;

   // request holds until req and gnt meet in one cycle
   modport requester (
      output req, addr, we, be, wdata,
      input  gnt, rvalid, rdata
   );

   // read data comes one cycle after the accepted read
   modport responder (
      input  req, addr, we, be, wdata,
      output gnt, rvalid, rdata
   );

endinterface

//--- riscv_mem_pkg.sv
package riscv_mem_pkg;

   // basic widths of the memory side
   localparam int WORD_W = 32;
   localparam int BE_W   = 4;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [BE_W-1:0]   be_t;

   // control word from the host
   // raw view feeds the edge detector, field view names the bits
   typedef union packed {
      word_t raw;
      struct packed {
         // reserved for later use
         logic [WORD_W-4:0] unused;
         // soft clear of the run state
         logic              clear;
         // kept free, not decoded
         logic              spare;
         // rising edge starts a run
         logic              start;
      } fields;
   } ctrl_word_u;

   // peripheral region begins here
   localparam word_t PERIPH_BASE_DEF = 32'h8000_0000;

   // a store of the success code here ends the program
   localparam word_t TOHOST_ADDR_DEF = 32'h8000_0000;

   // cycles from the finish store until stop
   localparam int unsigned DRAIN_CYCLES_DEF = 30;

endpackage

//--- riscv_mem_top.sv
`timescale 1ns/10ps

module riscv_mem_top #(
   parameter riscv_mem_pkg::word_t PERIPH_BASE  = riscv_mem_pkg::PERIPH_BASE_DEF,
   parameter riscv_mem_pkg::word_t TOHOST_ADDR  = riscv_mem_pkg::TOHOST_ADDR_DEF,
   parameter int unsigned          DRAIN_CYCLES = riscv_mem_pkg::DRAIN_CYCLES_DEF
) (
   input  logic                  clk,
   input  logic                  reset,

   // host control
   input  riscv_mem_pkg::word_t  control_i,
   input  riscv_mem_pkg::word_t  memory_offset_i,
   input  riscv_mem_pkg::word_t  success_code_i,

   // core-side load/store port
   input  logic                  req_i,
   input  riscv_mem_pkg::word_t  addr_i,
   input  logic                  we_i,
   input  riscv_mem_pkg::be_t    be_i,
   input  riscv_mem_pkg::word_t  wdata_i,
   output logic                  gnt_o,
   output logic                  rvalid_o,
   output riscv_mem_pkg::word_t  rdata_o,

   // run status
   output logic                  running_o,
   output logic                  stop_o,
   output riscv_mem_pkg::word_t  cycle_count_o,

   // data BRAM
   output logic                  data_mem_enb_o,
   output riscv_mem_pkg::be_t    data_mem_web_o,
   output riscv_mem_pkg::word_t  data_mem_addrb_o,
   output riscv_mem_pkg::word_t  data_mem_dinb_o,
   input  logic                  data_mem_rstb_busy_i,
   input  riscv_mem_pkg::word_t  data_mem_doutb_i,

   // peripheral BRAM
   output logic                  periph_mem_enb_o,
   output riscv_mem_pkg::be_t    periph_mem_web_o,
   output riscv_mem_pkg::word_t  periph_mem_addrb_o,
   output riscv_mem_pkg::word_t  periph_mem_dinb_o,
   input  logic                  periph_mem_rstb_busy_i,
   input  riscv_mem_pkg::word_t  periph_mem_doutb_i
);

   logic finish;

   mem_req_if data_bus ();
   mem_req_if periph_bus ();

   run_control #(
      .DRAIN_CYCLES (DRAIN_CYCLES)
   ) u_run_control (
      .clk           (clk),
      .reset         (reset),
      .control_i     (control_i),
      .finish_i      (finish),
      .running_o     (running_o),
      .stop_o        (stop_o),
      .cycle_count_o (cycle_count_o)
   );

   // requests only pass while the run flag is up
   data_port_router #(
      .PERIPH_BASE (PERIPH_BASE),
      .TOHOST_ADDR (TOHOST_ADDR)
   ) u_router (
      .clk             (clk),
      .reset           (reset),
      .run_en_i        (running_o),
      .req_i           (req_i),
      .addr_i          (addr_i),
      .we_i            (we_i),
      .be_i            (be_i),
      .wdata_i         (wdata_i),
      .memory_offset_i (memory_offset_i),
      .success_code_i  (success_code_i),
      .gnt_o           (gnt_o),
      .rvalid_o        (rvalid_o),
      .rdata_o         (rdata_o),
      .finish_o        (finish),
      .data_bus        (data_bus.requester),
      .periph_bus      (periph_bus.requester)
   );

   bram_port_adapter u_data_bram (
      .clk         (clk),
      .reset       (reset),
      .bus         (data_bus.responder),
      .enb_o       (data_mem_enb_o),
      .web_o       (data_mem_web_o),
      .addrb_o     (data_mem_addrb_o),
      .dinb_o      (data_mem_dinb_o),
      .rstb_busy_i (data_mem_rstb_busy_i),
      .doutb_i     (data_mem_doutb_i)
   );

   bram_port_adapter u_periph_bram (
      .clk         (clk),
      .reset       (reset),
      .bus         (periph_bus.responder),
      .enb_o       (periph_mem_enb_o),
      .web_o       (periph_mem_web_o),
      .addrb_o     (periph_mem_addrb_o),
      .dinb_o      (periph_mem_dinb_o),
      .rstb_busy_i (periph_mem_rstb_busy_i),
      .doutb_i     (periph_mem_doutb_i)
   );

endmodule

//--- run_control.sv
`timescale 1ns/10ps

module run_control #(
   parameter int unsigned DRAIN_CYCLES = riscv_mem_pkg::DRAIN_CYCLES_DEF
) (
   input  logic                       clk,
   input  logic                       reset,
   input  riscv_mem_pkg::ctrl_word_u  control_i,
   input  logic                       finish_i,
   output logic                       running_o,
   output logic                       stop_o,
   output riscv_mem_pkg::word_t       cycle_count_o
);
   import riscv_mem_pkg::*;

   // wide enough to reach DRAIN_CYCLES
   localparam int CNT_W = $clog2(DRAIN_CYCLES + 1);

   word_t      ctrl_prev;
   ctrl_word_u rise_w;
   logic       start_pulse;
   logic       clear_pulse;

   logic       running_q;
   logic       stop_q;
   logic       finish_seen_q;
   logic [CNT_W-1:0] drain_q;
   logic [CNT_W-1:0] drain_next;
   logic       finish_event;
   logic       drain_active;
   word_t      count_q;

   // previous control word, only used for edges
   always_ff @(posedge clk) begin
      ctrl_prev <= control_i.raw;
   end

   assign rise_w.raw  = control_i.raw & ~ctrl_prev;
   assign start_pulse = rise_w.fields.start;
   assign clear_pulse = rise_w.fields.clear;

   // only the first finish opens the drain window
   assign finish_event = finish_i & ~finish_seen_q;
   assign drain_active = (finish_event | finish_seen_q) & ~stop_q;
   // cycles elapsed since finish, as seen at the next edge
   assign drain_next   = finish_event ? CNT_W'(1) : drain_q + 1'b1;

   always_ff @(posedge clk) begin
      if (reset || clear_pulse) begin
         running_q     <= 1'b0;
         stop_q        <= 1'b0;
         finish_seen_q <= 1'b0;
         drain_q       <= '0;
         count_q       <= '0;
      end else begin
         // a stopped run needs a clear before it can start again
         if (start_pulse && !stop_q) begin
            running_q <= 1'b1;
            count_q   <= '0;
         end else if (running_q) begin
            count_q <= count_q + 1'b1;
         end
         if (drain_active) begin
            finish_seen_q <= 1'b1;
            drain_q       <= drain_next;
            if (drain_next == CNT_W'(DRAIN_CYCLES)) begin
               stop_q    <= 1'b1;
               running_q <= 1'b0;
            end
         end
      end
   end

   assign running_o     = running_q;
   assign stop_o        = stop_q;
   assign cycle_count_o = count_q;

   // a stopped design never runs
   a_stop_excludes_run: assert property (
      @(posedge clk) disable iff (reset) !(stop_o && running_o)
   );

endmodule

//--- tb_checker.sv
`timescale 1ns/10ps

module tb_checker #(
   parameter riscv_mem_pkg::word_t PERIPH_BASE  = riscv_mem_pkg::PERIPH_BASE_DEF,
   parameter riscv_mem_pkg::word_t TOHOST_ADDR  = riscv_mem_pkg::TOHOST_ADDR_DEF,
   parameter int unsigned          DRAIN_CYCLES = riscv_mem_pkg::DRAIN_CYCLES_DEF
) (
   input  logic clk,
   input  logic reset,
   input  riscv_mem_pkg::word_t control_i, memory_offset_i, success_code_i,
   input  logic req_i, we_i,
   input  riscv_mem_pkg::word_t addr_i, wdata_i,
   input  riscv_mem_pkg::be_t be_i,
   input  logic gnt_i, rvalid_i, running_i, stop_i,
   input  riscv_mem_pkg::word_t rdata_i, count_i,
   input  logic data_enb_i, data_busy_i, periph_enb_i, periph_busy_i,
   input  riscv_mem_pkg::be_t data_web_i, periph_web_i,
   input  riscv_mem_pkg::word_t data_addrb_i, data_dinb_i, periph_addrb_i, periph_dinb_i,
   input  int test_id_i,
   input  logic test_end_i,
   input  logic report_i,
   output int error_count_o
);
   import riscv_mem_pkg::*;

   word_t data_mem [256];
   word_t periph_mem [256];
   logic m_run, m_stop, m_seen, rd_pend, periph, acc, fin, n_run;
   int unsigned m_age;
   word_t m_count, m_prev, rd_exp, rebased;
   logic [7:0] idx;
   int test_errs = 0, tests_run = 0, tests_failed = 0;

   // mismatches after the last test still count
   assign error_count_o = tests_failed + test_errs;

   initial begin
      for (int i = 0; i < 256; i++) begin
         data_mem[i] = {8'(i), ~8'(i), 8'(i) + 8'h3c, 8'ha5 ^ 8'(i)};
         periph_mem[i] = {8'(i) ^ 8'h80, ~8'(i), 8'(i) + 8'h3c, 8'ha5 ^ 8'(i)};
      end
   end

   function automatic string name_of(input int id);
      case (id)
         1: return "idle";
         2: return "routing";
         3: return "readback";
         4: return "backpressure";
         5: return "finish";
         default: return "clear";
      endcase
   endfunction

   function automatic word_t merge(input word_t old, input word_t d, input be_t b);
      for (int i = 0; i < 4; i++) begin
         if (b[i]) old[i*8 +: 8] = d[i*8 +: 8];
      end
      return old;
   endfunction

   task automatic check_val(input string what, input word_t exp, input word_t act);
      if (exp !== act) begin
         $display("FAILED %s %s: expected %h, actual %h", name_of(test_id_i), what, exp, act);
         test_errs++;
      end
   endtask

   always @(posedge clk) begin
      periph = (addr_i >= PERIPH_BASE);
      if (reset) begin
         m_run = 1'b0;
         m_stop = 1'b0;
         m_seen = 1'b0;
         m_age = 0;
         m_count = '0;
         rd_pend = 1'b0;
      end else begin
         acc = req_i && m_run && !(periph ? periph_busy_i : data_busy_i);
         check_val("running", word_t'(m_run), word_t'(running_i));
         check_val("stop", word_t'(m_stop), word_t'(stop_i));
         check_val("count", m_count, count_i);
         check_val("gnt", word_t'(m_run && !(periph ? periph_busy_i : data_busy_i)),
                   word_t'(gnt_i));
         check_val("rvalid", word_t'(rd_pend), word_t'(rvalid_i));
         if (rd_pend) check_val("rdata", rd_exp, rdata_i);
         check_val("data enb", word_t'(acc && !periph), word_t'(data_enb_i));
         check_val("periph enb", word_t'(acc && periph), word_t'(periph_enb_i));
         rebased = periph ? addr_i - PERIPH_BASE : addr_i - memory_offset_i;
         idx = rebased[9:2];
         rd_pend = 1'b0;
         if (acc) begin
            check_val("addrb", {2'b00, rebased[31:2]}, periph ? periph_addrb_i : data_addrb_i);
            check_val("web", word_t'(we_i ? be_i : 4'h0),
                      word_t'(periph ? periph_web_i : data_web_i));
            if (we_i) begin
               check_val("dinb", wdata_i, periph ? periph_dinb_i : data_dinb_i);
               if (periph) periph_mem[idx] = merge(periph_mem[idx], wdata_i, be_i);
               else data_mem[idx] = merge(data_mem[idx], wdata_i, be_i);
            end else begin
               rd_pend = 1'b1;
               rd_exp = periph ? periph_mem[idx] : data_mem[idx];
            end
         end
         fin = acc && we_i && (addr_i == TOHOST_ADDR) && (wdata_i == success_code_i);
         if (control_i[2] && !m_prev[2]) begin
            m_run = 1'b0;
            m_stop = 1'b0;
            m_seen = 1'b0;
            m_age = 0;
            m_count = '0;
         end else begin
            n_run = m_run;
            if (control_i[0] && !m_prev[0] && !m_stop) begin
               n_run = 1'b1;
               m_count = '0;
            end else if (m_run) begin
               m_count = m_count + 1;
            end
            // the drain window opens on the first success store only
            if ((fin && !m_seen) || (m_seen && !m_stop)) begin
               m_age = (fin && !m_seen) ? 1 : m_age + 1;
               m_seen = 1'b1;
               if (m_age == DRAIN_CYCLES) begin
                  m_stop = 1'b1;
                  n_run = 1'b0;
               end
            end
            m_run = n_run;
         end
      end
      m_prev = control_i;
      if (test_end_i) begin
         tests_run++;
         if (test_errs != 0) tests_failed++;
         $display("test %s: %s, %0d errors", name_of(test_id_i),
                  (test_errs == 0) ? "ok" : "failing", test_errs);
         test_errs = 0;
      end
      if (report_i) begin
         $display("tests run %0d, tests failed %0d", tests_run, tests_failed);
      end
   end
endmodule

//--- tb_riscv_mem_top.sv
`timescale 1ns/10ps

// BRAM model with a one-cycle read and byte writes
module bram_model #(
   parameter logic [7:0] TAG = 8'h00
) (
   input  logic                  clk,
   input  logic                  enb_i,
   input  riscv_mem_pkg::be_t    web_i,
   input  riscv_mem_pkg::word_t  addrb_i,
   input  riscv_mem_pkg::word_t  dinb_i,
   output riscv_mem_pkg::word_t  doutb_o
);
   import riscv_mem_pkg::*;

   word_t mem [256];

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'(i) ^ TAG, ~8'(i), 8'(i) + 8'h3c, 8'ha5 ^ 8'(i)};
      end
      doutb_o = '0;
   end

   always @(posedge clk) begin
      if (enb_i) begin
         for (int b = 0; b < 4; b++) begin
            if (web_i[b]) begin
               mem[addrb_i[7:0]][b*8 +: 8] <= dinb_i[b*8 +: 8];
            end
         end
         if (web_i == '0) begin
            doutb_o <= mem[addrb_i[7:0]];
         end
      end
   end
endmodule

module tb_riscv_mem_top;
   import riscv_mem_pkg::*;

   localparam int N_WR = 40;
   localparam word_t OFFSET = 32'h0000_1000;
   localparam word_t SUCCESS = 32'h0000_0001;
   // idle, writes, reads, back-pressure, two drain windows, clear, margin
   localparam int LIMIT = 12 + N_WR * 16 + N_WR * 16 + 40 + 2 * DRAIN_CYCLES_DEF + 60 + 200;

   logic clk = 1'b0;
   logic reset;
   word_t control, addr, wdata, rdata, count;
   logic req, we, gnt, rvalid, running, stop;
   be_t be;
   logic d_enb, p_enb, d_busy, p_busy, force_busy;
   logic d_busy_rnd;
   be_t d_web, p_web;
   word_t d_addrb, p_addrb, d_dinb, p_dinb, d_dout, p_dout;
   logic [31:0] seed = 32'h1efd;
   logic [31:0] busy_seed = 32'h1efd;
   int cycles = 0;
   int test_id;
   logic test_end, report;
   int errors;
   word_t written [$];

   always #2 clk = ~clk;

   riscv_mem_top #(
      .PERIPH_BASE  (PERIPH_BASE_DEF),
      .TOHOST_ADDR  (TOHOST_ADDR_DEF),
      .DRAIN_CYCLES (DRAIN_CYCLES_DEF)
   ) u_dut (
      .clk (clk), .reset (reset), .control_i (control),
      .memory_offset_i (OFFSET), .success_code_i (SUCCESS),
      .req_i (req), .addr_i (addr), .we_i (we), .be_i (be), .wdata_i (wdata),
      .gnt_o (gnt), .rvalid_o (rvalid), .rdata_o (rdata),
      .running_o (running), .stop_o (stop), .cycle_count_o (count),
      .data_mem_enb_o (d_enb), .data_mem_web_o (d_web), .data_mem_addrb_o (d_addrb),
      .data_mem_dinb_o (d_dinb), .data_mem_rstb_busy_i (d_busy),
      .data_mem_doutb_i (d_dout),
      .periph_mem_enb_o (p_enb), .periph_mem_web_o (p_web),
      .periph_mem_addrb_o (p_addrb), .periph_mem_dinb_o (p_dinb),
      .periph_mem_rstb_busy_i (p_busy), .periph_mem_doutb_i (p_dout)
   );

   bram_model #(.TAG (8'h00)) u_data_mem (
      .clk (clk), .enb_i (d_enb), .web_i (d_web), .addrb_i (d_addrb),
      .dinb_i (d_dinb), .doutb_o (d_dout)
   );

   bram_model #(.TAG (8'h80)) u_periph_mem (
      .clk (clk), .enb_i (p_enb), .web_i (p_web), .addrb_i (p_addrb),
      .dinb_i (p_dinb), .doutb_o (p_dout)
   );

   tb_checker #(
      .PERIPH_BASE (PERIPH_BASE_DEF), .TOHOST_ADDR (TOHOST_ADDR_DEF),
      .DRAIN_CYCLES (DRAIN_CYCLES_DEF)
   ) u_checker (
      .clk (clk), .reset (reset), .control_i (control), .memory_offset_i (OFFSET),
      .success_code_i (SUCCESS), .req_i (req), .addr_i (addr), .we_i (we),
      .be_i (be), .wdata_i (wdata), .gnt_i (gnt), .rvalid_i (rvalid),
      .rdata_i (rdata), .running_i (running), .stop_i (stop), .count_i (count),
      .data_enb_i (d_enb), .data_web_i (d_web), .data_addrb_i (d_addrb),
      .data_dinb_i (d_dinb), .data_busy_i (d_busy),
      .periph_enb_i (p_enb), .periph_web_i (p_web), .periph_addrb_i (p_addrb),
      .periph_dinb_i (p_dinb), .periph_busy_i (p_busy),
      .test_id_i (test_id), .test_end_i (test_end), .report_i (report),
      .error_count_o (errors)
   );

   // random busy on both BRAMs, one cycle in four
   always @(negedge clk) begin
      d_busy_rnd <= (($random(busy_seed) & 3) == 0);
      p_busy <= (($random(busy_seed) & 3) == 0);
   end

   // forced busy holds the data BRAM off for the back-pressure test
   assign d_busy = force_busy | d_busy_rnd;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= LIMIT) begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("TEST FAILED");
         $finish;
      end
   end

   // called on a falling edge, returns on the falling edge after the grant
   task automatic access(input logic wr, input word_t a, input be_t b, input word_t d);
      req = 1'b1;
      we = wr;
      addr = a;
      be = b;
      wdata = d;
      do @(posedge clk); while (!gnt);
      @(negedge clk);
      req = 1'b0;
   endtask

   task automatic end_test();
      test_end = 1'b1;
      @(negedge clk);
      test_end = 1'b0;
   endtask

   function automatic word_t pick_addr();
      logic [7:0] idx;
      idx = 8'($random(seed));
      if ($random(seed) & 1) begin
         // word zero of the peripheral region is tohost
         if (idx == 8'h00) idx = 8'h01;
         return PERIPH_BASE_DEF + {22'b0, idx, 2'b00};
      end
      return OFFSET + {22'b0, idx, 2'b00};
   endfunction

   initial begin
      word_t a;
      be_t b;
      reset = 1'b1;
      control = '0;
      req = 1'b0;
      we = 1'b0;
      addr = '0;
      be = '0;
      wdata = '0;
      force_busy = 1'b0;
      d_busy_rnd = 1'b0;
      p_busy = 1'b0;
      test_id = 0;
      test_end = 1'b0;
      report = 1'b0;
      repeat (8) @(negedge clk);
      reset = 1'b0;

      // requests before start must be ignored
      test_id = 1;
      req = 1'b1;
      addr = OFFSET;
      repeat (12) @(negedge clk);
      req = 1'b0;
      end_test();

      test_id = 2;
      control = 32'h1;
      do @(negedge clk); while (!running);
      for (int i = 0; i < N_WR; i++) begin
         a = pick_addr();
         b = 4'($random(seed));
         if (b == '0) b = 4'hf;
         access(1'b1, a, b, $random(seed));
         written.push_back(a);
      end
      end_test();

      test_id = 3;
      foreach (written[i]) access(1'b0, written[i], 4'hf, '0);
      @(negedge clk);
      end_test();

      test_id = 4;
      force_busy = 1'b1;
      req = 1'b1;
      we = 1'b1;
      addr = OFFSET + 32'h40;
      be = 4'hf;
      wdata = 32'hcafe_f00d;
      repeat (6) @(negedge clk);
      force_busy = 1'b0;
      do @(posedge clk); while (!gnt);
      @(negedge clk);
      req = 1'b0;
      end_test();

      // wrong code first, then the success store
      test_id = 5;
      access(1'b1, TOHOST_ADDR_DEF, 4'hf, SUCCESS ^ 32'h5);
      repeat (DRAIN_CYCLES_DEF + 5) @(negedge clk);
      access(1'b1, TOHOST_ADDR_DEF, 4'hf, SUCCESS);
      do @(negedge clk); while (!stop);
      req = 1'b1;
      we = 1'b0;
      addr = OFFSET;
      repeat (10) @(negedge clk);
      req = 1'b0;
      end_test();

      test_id = 6;
      control = 32'h0;
      @(negedge clk);
      control = 32'h4;
      @(negedge clk);
      control = 32'h0;
      @(negedge clk);
      control = 32'h1;
      do @(negedge clk); while (!running);
      repeat (10) @(negedge clk);
      end_test();

      report = 1'b1;
      @(negedge clk);
      if (errors == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end
endmodule
